// ==== hdl/organ_pkg.sv ====
package organ_pkg;

  // ====================================================================
  // Widths
  // ====================================================================
  localparam int SAMPLE_W = 8;
  localparam int SEG_W    = 7;
  localparam int COUNT_W  = 16;
  localparam int NOTE_W   = 3;
  localparam int HALF_W   = 16;
  localparam int DIV_W    = 32;

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  // Active low, segment a in bit 0
  typedef logic [SEG_W-1:0]           seg_t;
  typedef logic [COUNT_W-1:0]         count_t;
  typedef logic [NOTE_W-1:0]          note_t;

  // ====================================================================
  // Note table and sample levels
  // ====================================================================
  // Half-periods in CLK_50M cycles, Do up to high Do
  localparam logic [HALF_W-1:0] NOTE_HALF_PERIOD [8] = '{
    16'd47801, 16'd42589, 16'd37936, 16'd35817,
    16'd31928, 16'd28409, 16'd25329, 16'd23900
  };

  localparam sample_t SAMPLE_HIGH = 8'sh7F;
  localparam sample_t SAMPLE_LOW  = 8'sh80;

  // Sampling count
  localparam count_t COUNT_DEFAULT = 16'd12499;
  localparam count_t COUNT_STEP    = 16'd100;

  // ====================================================================
  // Default tick divisors
  // ====================================================================
  localparam logic [DIV_W-1:0] LED_DIV_DEF    = 32'd25_000_000;
  localparam logic [DIV_W-1:0] SCAN_DIV_DEF   = 32'd5_000_000;
  localparam logic [DIV_W-1:0] DISP_DIV_DEF   = 32'd25_000_000;
  localparam logic [DIV_W-1:0] SAMPLE_DIV_DEF = 32'd1042;

endpackage

// ==== hdl/tick_gen.sv ====
`timescale 1ns/1ps

module tick_gen #(
  parameter logic [31:0] DIV = 32'd2
) (
  input  logic CLK_50M,
  input  logic rst_i,
  output logic tick_o
);

  logic [31:0] cnt;

  // Down-counter, pulse on the reload
  always_ff @(posedge CLK_50M)
  begin
    if (rst_i)
    begin
      cnt    <= DIV - 32'd1;
      tick_o <= 1'b0;
    end
    else if (cnt == 32'd0)
    begin
      cnt    <= DIV - 32'd1;
      tick_o <= 1'b1;
    end
    else
    begin
      cnt    <= cnt - 32'd1;
      tick_o <= 1'b0;
    end
  end

endmodule

// ==== hdl/tone_gen.sv ====
`timescale 1ns/1ps

module tone_gen #(
  parameter logic [31:0] SAMPLE_DIV = organ_pkg::SAMPLE_DIV_DEF
) (
  input  logic              CLK_50M,
  input  logic              rst_i,
  input  logic              enable_i,
  input  organ_pkg::note_t  note_i,
  output organ_pkg::sample_t sample_o,
  output logic              sample_valid_o,
  input  logic              sample_ready_i
);

  import organ_pkg::*;

  logic        en_meta, en_sync;
  note_t       note_meta, note_sync, note_q;
  logic [15:0] half_cnt;
  logic        level;
  logic [31:0] samp_cnt;
  logic        samp_tick;
  sample_t     next_sample;

  // Two-stage switch synchronizer
  always_ff @(posedge CLK_50M)
  begin
    if (rst_i)
    begin
      en_meta   <= 1'b0;
      en_sync   <= 1'b0;
      note_meta <= '0;
      note_sync <= '0;
    end
    else
    begin
      en_meta   <= enable_i;
      en_sync   <= en_meta;
      note_meta <= note_i;
      note_sync <= note_meta;
    end
  end

  // ====================================================================
  // Square wave, restarted on a note change
  // ====================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (rst_i)
    begin
      note_q   <= '0;
      half_cnt <= '0;
      level    <= 1'b0;
    end
    else if (note_sync != note_q)
    begin
      note_q   <= note_sync;
      half_cnt <= '0;
    end
    else if (half_cnt == NOTE_HALF_PERIOD[note_q] - 16'd1)
    begin
      half_cnt <= '0;
      level    <= ~level;
    end
    else
    begin
      half_cnt <= half_cnt + 16'd1;
    end
  end

  // ====================================================================
  // Sample stream with valid/ready
  // ====================================================================
  assign samp_tick   = (samp_cnt == 32'd0);
  assign next_sample = !en_sync ? sample_t'(0) : (level ? SAMPLE_HIGH : SAMPLE_LOW);

  always_ff @(posedge CLK_50M)
  begin
    if (rst_i)
    begin
      samp_cnt       <= SAMPLE_DIV - 32'd1;
      sample_o       <= '0;
      sample_valid_o <= 1'b0;
    end
    else
    begin
      samp_cnt <= samp_tick ? SAMPLE_DIV - 32'd1 : samp_cnt - 32'd1;
      // Tick is dropped while a sample waits for ready
      if (samp_tick && (!sample_valid_o || sample_ready_i))
      begin
        sample_o       <= next_sample;
        sample_valid_o <= 1'b1;
      end
      else if (sample_valid_o && sample_ready_i)
      begin
        sample_valid_o <= 1'b0;
      end
    end
  end

endmodule

// ==== hdl/led_bounce.sv ====
`timescale 1ns/1ps

module led_bounce (
  input  logic       CLK_50M,
  input  logic       rst_i,
  input  logic       step_i,
  output logic [7:0] led_o
);

  // 1 while moving toward bit 7
  logic dir_up;

  always_ff @(posedge CLK_50M)
  begin
    if (rst_i)
    begin
      led_o  <= 8'h01;
      dir_up <= 1'b1;
    end
    else if (step_i)
    begin
      if (dir_up)
      begin
        // Turn around at the top end
        if (led_o[7])
        begin
          dir_up <= 1'b0;
          led_o  <= led_o >> 1;
        end
        else
        begin
          led_o <= led_o << 1;
        end
      end
      else if (led_o[0])
      begin
        dir_up <= 1'b1;
        led_o  <= led_o << 1;
      end
      else
      begin
        led_o <= led_o >> 1;
      end
    end
  end

endmodule

// ==== hdl/speed_ctrl.sv ====
`timescale 1ns/1ps

module speed_ctrl (
  input  logic              CLK_50M,
  input  logic              rst_i,
  input  logic [2:0]        key_n_i,
  input  logic              scan_i,
  output organ_pkg::count_t count_o
);

  import organ_pkg::*;

  logic [2:0] key_meta;
  logic [2:0] key_sync;
  logic       up_held;
  logic       down_held;
  logic       clr_held;
  logic       step_up;
  logic       step_down;

  // Keys are active low, held here as active high
  always_ff @(posedge CLK_50M)
  begin
    if (rst_i)
    begin
      key_meta <= 3'b000;
      key_sync <= 3'b000;
    end
    else
    begin
      key_meta <= ~key_n_i;
      key_sync <= key_meta;
    end
  end

  assign up_held   = key_sync[0];
  assign down_held = key_sync[1];
  assign clr_held  = key_sync[2];

  // One step per scan tick, opposing keys cancel
  assign step_up   = scan_i && up_held && !down_held;
  assign step_down = scan_i && down_held && !up_held;

  // Wraps modulo 2^16
  always_ff @(posedge CLK_50M)
  begin
    if (rst_i || clr_held)
    begin
      count_o <= COUNT_DEFAULT;
    end
    else if (step_up)
    begin
      count_o <= count_o + COUNT_STEP;
    end
    else if (step_down)
    begin
      count_o <= count_o - COUNT_STEP;
    end
  end

endmodule

// ==== hdl/hex_display.sv ====
`timescale 1ns/1ps

module hex_display (
  input  logic              CLK_50M,
  input  logic              rst_i,
  input  organ_pkg::count_t count_i,
  input  logic              update_i,
  output organ_pkg::seg_t   hex0_o,
  output organ_pkg::seg_t   hex1_o,
  output organ_pkg::seg_t   hex2_o,
  output organ_pkg::seg_t   hex3_o,
  output organ_pkg::seg_t   hex4_o,
  output organ_pkg::seg_t   hex5_o
);

  import organ_pkg::*;

  logic [23:0] shown;

  // Nibble to active-low segments, gfedcba
  function automatic seg_t seg_of(input logic [3:0] nib);
    case (nib)
      4'h0: seg_of = 7'h40;
      4'h1: seg_of = 7'h79;
      4'h2: seg_of = 7'h24;
      4'h3: seg_of = 7'h30;
      4'h4: seg_of = 7'h19;
      4'h5: seg_of = 7'h12;
      4'h6: seg_of = 7'h02;
      4'h7: seg_of = 7'h78;
      4'h8: seg_of = 7'h00;
      4'h9: seg_of = 7'h10;
      4'hA: seg_of = 7'h08;
      4'hB: seg_of = 7'h03;
      4'hC: seg_of = 7'h46;
      4'hD: seg_of = 7'h21;
      4'hE: seg_of = 7'h06;
      default: seg_of = 7'h0E;
    endcase
  endfunction

  always_ff @(posedge CLK_50M)
  begin
    if (rst_i)
      shown <= '0;
    else if (update_i)
      shown <= {8'h00, count_i};
  end

  assign hex0_o = seg_of(shown[3:0]);
  assign hex1_o = seg_of(shown[7:4]);
  assign hex2_o = seg_of(shown[11:8]);
  assign hex3_o = seg_of(shown[15:12]);
  assign hex4_o = seg_of(shown[19:16]);
  assign hex5_o = seg_of(shown[23:20]);

endmodule

// ==== hdl/organ_top.sv ====
`timescale 1ns/1ps

module organ_top #(
  parameter logic [31:0] LED_DIV    = organ_pkg::LED_DIV_DEF,
  parameter logic [31:0] SCAN_DIV   = organ_pkg::SCAN_DIV_DEF,
  parameter logic [31:0] DISP_DIV   = organ_pkg::DISP_DIV_DEF,
  parameter logic [31:0] SAMPLE_DIV = organ_pkg::SAMPLE_DIV_DEF
) (
  input  logic               CLK_50M,
  input  logic               rst_i,
  input  logic [9:0]         sw_i,
  input  logic [2:0]         key_n_i,
  output logic [7:0]         led_o,
  output organ_pkg::seg_t    hex0_o,
  output organ_pkg::seg_t    hex1_o,
  output organ_pkg::seg_t    hex2_o,
  output organ_pkg::seg_t    hex3_o,
  output organ_pkg::seg_t    hex4_o,
  output organ_pkg::seg_t    hex5_o,
  output organ_pkg::sample_t sample_o,
  output logic               sample_valid_o,
  input  logic               sample_ready_i
);

  import organ_pkg::*;

  logic   led_tick;
  logic   scan_tick;
  logic   disp_tick;
  count_t count;

  // ====================================================================
  // Clock-enable ticks
  // ====================================================================
  tick_gen #(.DIV(LED_DIV)) led_tick_i (
    .CLK_50M (CLK_50M), .rst_i (rst_i), .tick_o (led_tick)
  );

  tick_gen #(.DIV(SCAN_DIV)) scan_tick_i (
    .CLK_50M (CLK_50M), .rst_i (rst_i), .tick_o (scan_tick)
  );

  tick_gen #(.DIV(DISP_DIV)) disp_tick_i (
    .CLK_50M (CLK_50M), .rst_i (rst_i), .tick_o (disp_tick)
  );

  // ====================================================================
  // Audio, LEDs, speed count and display
  // ====================================================================
  // sw_i[0] enables audio, sw_i[3:1] picks the note
  tone_gen #(.SAMPLE_DIV(SAMPLE_DIV)) tone_gen_i (
    .CLK_50M (CLK_50M), .rst_i (rst_i),
    .enable_i (sw_i[0]), .note_i (sw_i[3:1]),
    .sample_o (sample_o), .sample_valid_o (sample_valid_o),
    .sample_ready_i (sample_ready_i)
  );

  led_bounce led_bounce_i (
    .CLK_50M (CLK_50M), .rst_i (rst_i), .step_i (led_tick), .led_o (led_o)
  );

  speed_ctrl speed_ctrl_i (
    .CLK_50M (CLK_50M), .rst_i (rst_i),
    .key_n_i (key_n_i), .scan_i (scan_tick), .count_o (count)
  );

  hex_display hex_display_i (
    .CLK_50M (CLK_50M), .rst_i (rst_i),
    .count_i (count), .update_i (disp_tick),
    .hex0_o (hex0_o), .hex1_o (hex1_o), .hex2_o (hex2_o),
    .hex3_o (hex3_o), .hex4_o (hex4_o), .hex5_o (hex5_o)
  );

endmodule

// ==== test/organ_props.sv ====
`timescale 1ns/1ps

module organ_props (
  input logic               CLK_50M,
  input logic               rst_i,
  input logic [7:0]         led_o,
  input organ_pkg::sample_t sample_o,
  input logic               sample_valid_o,
  input logic               sample_ready_i
);

  import organ_pkg::*;

  a_led_onehot: assert property (@(posedge CLK_50M) disable iff (rst_i) $onehot(led_o))
    else $error("led_o is not one-hot");

  // Pending sample must hold until accepted
  a_sample_hold: assert property (@(posedge CLK_50M) disable iff (rst_i)
    (sample_valid_o && !sample_ready_i) |=> (sample_valid_o && $stable(sample_o)))
    else $error("sample changed or was withdrawn while stalled");

  a_valid_after_reset: assert property (@(posedge CLK_50M) rst_i |=> !sample_valid_o)
    else $error("sample_valid_o high in the cycle after reset");

  a_sample_legal: assert property (@(posedge CLK_50M) disable iff (rst_i)
    sample_valid_o |-> (sample_o == SAMPLE_HIGH || sample_o == SAMPLE_LOW
                        || sample_o == sample_t'(0)))
    else $error("illegal sample value");

endmodule

bind organ_top organ_props props_i (
  .CLK_50M (CLK_50M), .rst_i (rst_i), .led_o (led_o), .sample_o (sample_o),
  .sample_valid_o (sample_valid_o), .sample_ready_i (sample_ready_i)
);

// ==== test/organ_tb.sv ====
`timescale 1ns/1ps

module organ_tb;

  import organ_pkg::*;

  localparam int LED_DIV    = 40;
  localparam int SCAN_DIV   = 50;
  localparam int DISP_DIV   = 30;
  localparam int SAMPLE_DIV = 1042;
  localparam int KEY_UP     = 0;
  localparam int KEY_DOWN   = 1;
  localparam int KEY_CLR    = 2;

  logic        CLK_50M;
  logic        rst_i;
  logic [9:0]  sw_i;
  logic [2:0]  key_n_i;
  logic [7:0]  led_o;
  seg_t        hex0_o, hex1_o, hex2_o, hex3_o, hex4_o, hex5_o;
  sample_t     sample_o;
  logic        sample_valid_o;
  logic        sample_ready_i;
  logic [41:0] hex_all;

  int          n_err, mon_err, n_checks, n_tests, err_mark;
  logic        abort;
  logic [31:0] rng;
  sample_t     acc_q [$];
  logic        mon_v, mon_r;
  sample_t     mon_s;

  organ_top #(
    .LED_DIV (LED_DIV), .SCAN_DIV (SCAN_DIV), .DISP_DIV (DISP_DIV), .SAMPLE_DIV (SAMPLE_DIV)
  ) dut_i (
    .CLK_50M (CLK_50M), .rst_i (rst_i), .sw_i (sw_i), .key_n_i (key_n_i), .led_o (led_o),
    .hex0_o (hex0_o), .hex1_o (hex1_o), .hex2_o (hex2_o),
    .hex3_o (hex3_o), .hex4_o (hex4_o), .hex5_o (hex5_o),
    .sample_o (sample_o), .sample_valid_o (sample_valid_o), .sample_ready_i (sample_ready_i)
  );

  assign hex_all = {hex5_o, hex4_o, hex3_o, hex2_o, hex1_o, hex0_o};

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  // ====================================================================
  // Reference models
  // ====================================================================
  function automatic logic [7:0] next_led(input logic [7:0] cur, input logic up);
    if (up)
      return cur[7] ? (cur >> 1) : (cur << 1);
    return cur[0] ? (cur << 1) : (cur >> 1);
  endfunction

  function automatic sample_t exp_sample(input logic level, input logic en);
    if (!en)
      return sample_t'(0);
    return level ? SAMPLE_HIGH : SAMPLE_LOW;
  endfunction

  // Active-low segments in gfedcba order
  function automatic seg_t seg_ref(input logic [3:0] nib);
    case (nib)
      4'h0: return 7'b1000000;
      4'h1: return 7'b1111001;
      4'h2: return 7'b0100100;
      4'h3: return 7'b0110000;
      4'h4: return 7'b0011001;
      4'h5: return 7'b0010010;
      4'h6: return 7'b0000010;
      4'h7: return 7'b1111000;
      4'h8: return 7'b0000000;
      4'h9: return 7'b0010000;
      4'hA: return 7'b0001000;
      4'hB: return 7'b0000011;
      4'hC: return 7'b1000110;
      4'hD: return 7'b0100001;
      4'hE: return 7'b0000110;
      default: return 7'b0001110;
    endcase
  endfunction

  function automatic count_t key_ref(input count_t c, input int key);
    case (key)
      KEY_UP:   return c + COUNT_STEP;
      KEY_DOWN: return c - COUNT_STEP;
      default:  return COUNT_DEFAULT;
    endcase
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int total_err();
    return n_err + mon_err;
  endfunction

  // ====================================================================
  // Compare tasks
  // ====================================================================
  task automatic check_sample(input string name, input sample_t exp, input sample_t act);
    n_checks++;
    if (act !== exp)
    begin
      n_err++;
      $display("ERR %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_led(input string name, input logic [7:0] exp, input logic [7:0] act);
    n_checks++;
    if (act !== exp)
    begin
      n_err++;
      $display("ERR %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_hex(input string name, input seg_t h0, input seg_t h1, input seg_t h2,
                           input seg_t h3, input seg_t h4, input seg_t h5, input count_t exp);
    logic [23:0] val;
    logic [41:0] want;
    logic [41:0] got;
    val  = {8'h00, exp};
    got  = {h5, h4, h3, h2, h1, h0};
    for (int i = 0; i < 6; i++)
      want[i*7 +: 7] = seg_ref(val[i*4 +: 4]);
    n_checks++;
    if (got !== want)
    begin
      n_err++;
      $display("ERR %s expected %0d (segments %h) actual segments %h", name, exp, want, got);
    end
  endtask

  task automatic check_run(input string name, input int lo, input int hi, input int act);
    n_checks++;
    if (act < lo || act > hi)
    begin
      n_err++;
      $display("ERR %s expected run %0d..%0d actual %0d", name, lo, hi, act);
    end
  endtask

  // ====================================================================
  // Sequencing helpers
  // ====================================================================
  task automatic next_cycle();
    @(posedge CLK_50M);
    #1;
  endtask

  task automatic timeout_hit(input string what);
    $display("Timeout while waiting for %s", what);
    n_err++;
    abort = 1'b1;
  endtask

  task automatic end_test(input string name);
    n_tests++;
    $display("test %s: %s, %0d errors", name, (total_err() == err_mark) ? "ok" : "failed",
             total_err() - err_mark);
    err_mark = total_err();
  endtask

  task automatic wait_display_change(input int limit);
    logic [41:0] old;
    int          n;
    old = hex_all;
    n   = 0;
    while (!abort && hex_all == old && n < limit)
    begin
      next_cycle();
      n++;
    end
    if (!abort && hex_all == old)
      timeout_hit("a display change");
  endtask

  task automatic wait_led_change(input logic [7:0] prev, input int limit);
    int n;
    n = 0;
    while (!abort && led_o == prev && n < limit)
    begin
      next_cycle();
      n++;
    end
    if (!abort && led_o == prev)
      timeout_hit("an LED step");
  endtask

  // Ready comes from the LCG when rand_rdy is set
  task automatic collect(input int n, input logic rand_rdy);
    int limit;
    int k;
    acc_q.delete();
    limit = n * SAMPLE_DIV * 8;
    k     = 0;
    while (!abort && acc_q.size() < n && k < limit)
    begin
      next_cycle();
      if (rand_rdy)
      begin
        rng            = lcg_next(rng);
        sample_ready_i = rng[31];
      end
      k++;
    end
    if (!abort && acc_q.size() < n)
      timeout_hit("audio samples");
  endtask

  // Splits accepted samples into runs of equal level and skips the partial first run
  task automatic check_runs(input string name, input int lo, input int hi, input int min_runs);
    logic level;
    logic first;
    int   run;
    int   done;
    if (acc_q.size() == 0)
      return;
    level = (acc_q[0] == exp_sample(1'b1, 1'b1));
    first = 1'b1;
    run   = 0;
    done  = 0;
    foreach (acc_q[i])
    begin
      if (acc_q[i] != exp_sample(level, 1'b1))
      begin
        level = ~level;
        check_sample(name, exp_sample(level, 1'b1), acc_q[i]);
        if (!first)
        begin
          check_run(name, lo, hi, run);
          done++;
        end
        first = 1'b0;
        run   = 0;
      end
      run++;
    end
    if (done < min_runs)
    begin
      n_err++;
      $display("Only %0d complete sample runs seen in %s", done, name);
    end
  endtask

  // ====================================================================
  // Sample monitor
  // ====================================================================
  // Transfer happens at the next rising edge when both are high here
  always @(negedge CLK_50M)
  begin
    if (!rst_i)
    begin
      if (mon_v && !mon_r && (!sample_valid_o || sample_o !== mon_s))
      begin
        mon_err++;
        $display("Pending sample was dropped or changed while ready was low");
      end
      if (sample_valid_o && sample_ready_i)
        acc_q.push_back(sample_o);
    end
    mon_v = sample_valid_o && !rst_i;
    mon_r = sample_ready_i;
    mon_s = sample_o;
  end

  // ====================================================================
  // Test sequence
  // ====================================================================
  initial
  begin
    logic [7:0] prev;
    logic [7:0] exp_led;
    logic       up;
    int         runlen;
    count_t     ref_count;
    note_t      notes [3];
    int         keys [4];
    rst_i          = 1'b1;
    sw_i           = '0;
    key_n_i        = 3'b111;
    sample_ready_i = 1'b0;
    n_err          = 0;
    mon_err        = 0;
    n_checks       = 0;
    n_tests        = 0;
    err_mark       = 0;
    abort          = 1'b0;
    mon_v          = 1'b0;
    mon_r          = 1'b0;
    mon_s          = '0;
    rng            = 32'hb1d4045f;
    notes          = '{3'd0, 3'd3, 3'd7};
    keys           = '{KEY_UP, KEY_UP, KEY_DOWN, KEY_CLR};
    repeat (3) next_cycle();
    rst_i = 1'b0;

    check_led("reset", 8'h01, led_o);
    n_checks++;
    if (sample_valid_o !== 1'b0)
    begin
      n_err++;
      $display("ERR reset expected sample_valid_o %b actual %b", 1'b0, sample_valid_o);
    end
    check_hex("reset", hex0_o, hex1_o, hex2_o, hex3_o, hex4_o, hex5_o, 16'h0000);
    wait_display_change(3 * DISP_DIV);
    check_hex("reset", hex0_o, hex1_o, hex2_o, hex3_o, hex4_o, hex5_o, COUNT_DEFAULT);
    end_test("reset");

    prev = 8'h01;
    up   = 1'b1;
    for (int i = 0; i < 28 && !abort; i++)
    begin
      wait_led_change(prev, 3 * LED_DIV);
      exp_led = next_led(prev, up);
      check_led("led_bounce", exp_led, led_o);
      up   = (exp_led > prev);
      prev = led_o;
    end
    end_test("led_bounce");

    sample_ready_i = 1'b1;
    collect(8, 1'b0);
    foreach (acc_q[i])
      check_sample("tone_off", exp_sample(1'b0, 1'b0), acc_q[i]);
    end_test("tone_off");

    for (int j = 0; j < 3; j++)
    begin
      sw_i   = {6'b000000, notes[j], 1'b1};
      runlen = int'(NOTE_HALF_PERIOD[notes[j]]) / SAMPLE_DIV;
      // Flush samples taken before the note change
      collect(3, 1'b0);
      collect(5 * (runlen + 2), 1'b0);
      check_runs($sformatf("tone_note%0d", notes[j]), runlen - 1, runlen + 1, 3);
      end_test($sformatf("tone_note%0d", notes[j]));
    end

    // Note 7 still selected
    collect(60, 1'b1);
    check_runs("backpressure", 1, runlen + 1, 1);
    sample_ready_i = 1'b1;
    end_test("backpressure");

    ref_count = COUNT_DEFAULT;
    for (int k = 0; k < 4; k++)
    begin
      key_n_i[keys[k]] = 1'b0;
      wait_display_change(3 * (SCAN_DIV + DISP_DIV));
      key_n_i = 3'b111;
      repeat (4) next_cycle();
      ref_count = key_ref(ref_count, keys[k]);
      check_hex($sformatf("speed_keys step %0d", k), hex0_o, hex1_o, hex2_o,
                hex3_o, hex4_o, hex5_o, ref_count);
    end
    end_test("speed_keys");

    $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, total_err());
    if (total_err() == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== build.f ====
hdl/organ_pkg.sv
hdl/tick_gen.sv
hdl/tone_gen.sv
hdl/led_bounce.sv
hdl/speed_ctrl.sv
hdl/hex_display.sv
hdl/organ_top.sv
test/organ_props.sv
test/organ_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the organ testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module organ_tb -o organ_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/organ_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q '^\*\*\* PASSED \*\*\*$'; then
  exit 0
fi
exit 1
